// File: all.f
hw/bp_pkg.sv
hw/bp_btb.sv
hw/bp_gshare.sv
hw/bp_predictor.sv
hw/bp_csr.sv
hw/bp_top.sv
sim/tb_bp_top.sv

// File: hw/bp_btb.sv
// Four-lane direct-mapped BTB, registered lookup and commit-time fill
`timescale 1ns/1ps
`default_nettype none

module bp_btb
  import bp_pkg::*;
#(
  parameter int unsigned BTB_IDX_W = 6
) (
  input  wire              i_clk,
  input  wire              i_arst_n,
  input  wire              i_s0_valid,
  input  vaddr_t           i_s0_pc,
  input  bp_update_t       i_update,
  output lane_mask_t       o_s1_hit_mask,
  output vaddr_t [3:0]     o_s1_targets
);

  localparam int unsigned ROWS  = 1 << BTB_IDX_W;
  localparam int unsigned TAG_W = 32 - 4 - BTB_IDX_W;

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [TAG_W-1:0]     btb_tag_t;

  // Storage, valid per lane plus tag and target per lane
  logic [ROWS-1:0][3:0] r_valid;
  btb_tag_t [3:0]       r_tag    [ROWS];
  vaddr_t [3:0]         r_target [ROWS];

  btb_idx_t  w_s0_idx;
  btb_tag_t  w_s0_tag;
  btb_idx_t  w_upd_idx;
  btb_tag_t  w_upd_tag;
  lane_idx_t w_upd_lane;
  logic      w_upd_fill;

  // s1 copies of the row read at s0
  logic           r_s1_valid;
  btb_tag_t       r_s1_tag;
  lane_mask_t     r_s1_row_valid;
  btb_tag_t [3:0] r_s1_row_tag;
  vaddr_t [3:0]   r_s1_targets;

  // Block index from bit 4, tag is everything above it
  assign w_s0_idx   = i_s0_pc[4 +: BTB_IDX_W];
  assign w_s0_tag   = i_s0_pc[31 -: TAG_W];
  assign w_upd_idx  = i_update.pc[4 +: BTB_IDX_W];
  assign w_upd_tag  = i_update.pc[31 -: TAG_W];
  assign w_upd_lane = i_update.pc[3:2];
  // Only taken branches allocate
  assign w_upd_fill = i_update.valid && i_update.taken;

  // --------------------
  // Commit write
  // --------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_valid <= '0;
    end else if (w_upd_fill) begin
      r_valid[w_upd_idx][w_upd_lane] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_upd_fill) begin
      r_tag[w_upd_idx][w_upd_lane]    <= w_upd_tag;
      r_target[w_upd_idx][w_upd_lane] <= i_update.target;
    end
  end

  // --------------------
  // Lookup
  // --------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_s1_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid;
    end
  end

  // Row snapshot, held when idle
  always_ff @(posedge i_clk) begin
    if (i_s0_valid) begin
      r_s1_tag       <= w_s0_tag;
      r_s1_row_valid <= r_valid[w_s0_idx];
      r_s1_row_tag   <= r_tag[w_s0_idx];
      r_s1_targets   <= r_target[w_s0_idx];
    end
  end

  // Per-lane tag compare
  always_comb begin
    for (int l = 0; l < 4; l++) begin
      o_s1_hit_mask[l] = r_s1_valid && r_s1_row_valid[l] && (r_s1_row_tag[l] == r_s1_tag);
    end
  end

  assign o_s1_targets = r_s1_targets;

  // Commit side only delivers word-aligned branch addresses
  a_upd_aligned : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_update.valid |-> (i_update.pc[1:0] == 2'b00)
  );

endmodule

`default_nettype wire

// File: hw/bp_csr.sv
// AXI4-Lite register block, predictor control, event counters, history
`timescale 1ns/1ps
`default_nettype none

module bp_csr
  import bp_pkg::*;
#(
  parameter int unsigned GHIST_W = 8
) (
  input  wire                 i_clk,
  input  wire                 i_arst_n,
  input  axil_req_t           i_axil,
  output axil_resp_t          o_axil,
  output bp_ctrl_t            o_ctrl,
  input  wire                 i_lookup_evt,
  input  wire                 i_taken_evt,
  input  wire [GHIST_W-1:0]   i_ghist
);

  axil_wr_state_e r_wr_state;
  axil_addr_t     r_awaddr;
  logic           r_awready;
  logic           r_wready;
  logic           r_bvalid;
  logic           r_arready;
  logic           r_rvalid;
  axil_data_t     r_rdata;
  axil_data_t     w_rd_mux;
  logic           w_wr_fire;
  logic           r_predict_en;
  logic           r_hist_clear;
  logic [31:0]    r_lookups;
  logic [31:0]    r_taken;

  // --------------------
  // Write channel
  // --------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_wr_state <= WR_IDLE;
      r_awready  <= 1'b0;
      r_wready   <= 1'b0;
      r_bvalid   <= 1'b0;
    end else begin
      case (r_wr_state)
        WR_IDLE: begin
          r_awready <= 1'b1;
          if (i_axil.awvalid && r_awready) begin
            r_awready  <= 1'b0;
            r_wready   <= 1'b1;
            r_wr_state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_wr_fire) begin
            r_wready   <= 1'b0;
            r_bvalid   <= 1'b1;
            r_wr_state <= WR_RESP;
          end
        end
        WR_RESP: begin
          // Hold response until taken
          if (i_axil.bready) begin
            r_bvalid   <= 1'b0;
            r_wr_state <= WR_IDLE;
          end
        end
        default: r_wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_axil.awvalid && r_awready) begin
      r_awaddr <= i_axil.awaddr;
    end
  end

  assign w_wr_fire = (r_wr_state == WR_DATA) && i_axil.wvalid && r_wready;

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_predict_en <= 1'b1;
      r_hist_clear <= 1'b0;
    end else begin
      r_hist_clear <= 1'b0;
      if (w_wr_fire && (r_awaddr == REG_CTRL) && i_axil.wstrb[0]) begin
        r_predict_en <= i_axil.wdata[0];
        // Single-cycle pulse
        r_hist_clear <= i_axil.wdata[1];
      end
    end
  end

  // Counters, a write clears and wins over an event
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_lookups <= '0;
      r_taken   <= '0;
    end else begin
      if (w_wr_fire && (r_awaddr == REG_LOOKUPS)) begin
        r_lookups <= '0;
      end else if (i_lookup_evt) begin
        r_lookups <= r_lookups + 32'd1;
      end
      if (w_wr_fire && (r_awaddr == REG_TAKEN)) begin
        r_taken <= '0;
      end else if (i_taken_evt) begin
        r_taken <= r_taken + 32'd1;
      end
    end
  end

  // --------------------
  // Read channel
  // --------------------
  always_comb begin
    case (i_axil.araddr)
      REG_CTRL:    w_rd_mux = {31'd0, r_predict_en};
      REG_LOOKUPS: w_rd_mux = r_lookups;
      REG_TAKEN:   w_rd_mux = r_taken;
      REG_GHIST:   w_rd_mux = axil_data_t'(i_ghist);
      default:     w_rd_mux = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_arready <= 1'b0;
      r_rvalid  <= 1'b0;
    end else if (r_rvalid) begin
      if (i_axil.rready) begin
        r_rvalid <= 1'b0;
      end
    end else if (i_axil.arvalid && r_arready) begin
      r_arready <= 1'b0;
      r_rvalid  <= 1'b1;
    end else begin
      r_arready <= 1'b1;
    end
  end

  // Data captured at the ar handshake
  always_ff @(posedge i_clk) begin
    if (i_axil.arvalid && r_arready && !r_rvalid) begin
      r_rdata <= w_rd_mux;
    end
  end

  assign o_axil.awready = r_awready;
  assign o_axil.wready  = r_wready;
  assign o_axil.bvalid  = r_bvalid;
  assign o_axil.bresp   = AXI_RESP_OKAY;
  assign o_axil.arready = r_arready;
  assign o_axil.rvalid  = r_rvalid;
  assign o_axil.rdata   = r_rdata;
  assign o_axil.rresp   = AXI_RESP_OKAY;

  assign o_ctrl.predict_en = r_predict_en;
  assign o_ctrl.hist_clear = r_hist_clear;

  a_bvalid_hold : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (r_bvalid && !i_axil.bready) |=> r_bvalid
  );

endmodule

`default_nettype wire

// File: hw/bp_gshare.sv
// Gshare direction predictor with global history and 2-bit counter table
`timescale 1ns/1ps
`default_nettype none

module bp_gshare
  import bp_pkg::*;
#(
  parameter int unsigned PHT_IDX_W = 8,
  parameter int unsigned GHIST_W   = 8
) (
  input  wire                 i_clk,
  input  wire                 i_arst_n,
  input  wire                 i_s0_valid,
  input  vaddr_t              i_s0_pc,
  input  lane_idx_t           i_s1_lane,
  input  bp_update_t          i_update,
  input  wire                 i_hist_clear,
  output logic                o_s2_taken,
  output logic [GHIST_W-1:0]  o_ghist
);

  localparam int unsigned ROWS = 1 << PHT_IDX_W;

  typedef logic [PHT_IDX_W-1:0] pht_idx_t;

  // Counter table and global history
  bp_cnt_t [ROWS-1:0][3:0] r_pht;
  logic [GHIST_W-1:0]      r_ghist;

  pht_idx_t  w_hist_ext;
  pht_idx_t  w_s0_idx;
  pht_idx_t  w_upd_idx;
  lane_idx_t w_upd_lane;
  logic      w_upd_train;
  bp_cnt_t   w_upd_cnt;
  bp_cnt_t   w_upd_cnt_nxt;

  bp_cnt_t [3:0] r_s1_row;
  logic          r_s2_taken;

  // History zero-extended up to the index width
  assign w_hist_ext  = pht_idx_t'(r_ghist);
  assign w_s0_idx    = i_s0_pc[4 +: PHT_IDX_W] ^ w_hist_ext;
  // Pre-shift history for the training index
  assign w_upd_idx   = i_update.pc[4 +: PHT_IDX_W] ^ w_hist_ext;
  assign w_upd_lane  = i_update.pc[3:2];
  assign w_upd_train = i_update.valid && i_update.is_cond;

  // --------------------
  // Counter training
  // --------------------
  always_comb begin
    w_upd_cnt     = r_pht[w_upd_idx][w_upd_lane];
    w_upd_cnt_nxt = w_upd_cnt;
    if (i_update.taken) begin
      // Saturate at strongly taken
      if (w_upd_cnt != 2'b11) begin
        w_upd_cnt_nxt = w_upd_cnt + 2'd1;
      end
    end else if (w_upd_cnt != 2'b00) begin
      w_upd_cnt_nxt = w_upd_cnt - 2'd1;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int r = 0; r < ROWS; r++) begin
        r_pht[r] <= {4{CNT_WEAK_NT}};
      end
    end else if (w_upd_train) begin
      r_pht[w_upd_idx][w_upd_lane] <= w_upd_cnt_nxt;
    end
  end

  // Clear beats a same-cycle shift of the history
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_ghist <= '0;
    end else if (i_hist_clear) begin
      r_ghist <= '0;
    end else if (w_upd_train) begin
      // Oldest outcome drops off the top
      r_ghist <= GHIST_W'({r_ghist, i_update.taken});
    end
  end

  // --------------------
  // Lookup pipe
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_s0_valid) begin
      r_s1_row <= r_pht[w_s0_idx];
    end
  end

  // MSB of the lane picked by the BTB in s1 is the direction
  always_ff @(posedge i_clk) begin
    r_s2_taken <= r_s1_row[i_s1_lane][1];
  end

  assign o_s2_taken = r_s2_taken;
  assign o_ghist    = r_ghist;

endmodule

`default_nettype wire

// File: hw/bp_pkg.sv
// Branch predictor shared types, AXI4-Lite structs and register map
`default_nettype none

package bp_pkg;

  // --------------------
  // Basic widths
  // --------------------
  typedef logic [31:0] vaddr_t;
  typedef logic [3:0]  lane_mask_t;
  typedef logic [1:0]  lane_idx_t;
  typedef logic [1:0]  bp_cnt_t;
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // Counter reset value, weakly not taken
  localparam bp_cnt_t CNT_WEAK_NT = 2'b01;

  // Commit-time training record
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    vaddr_t target;
    logic   taken;
    logic   is_cond;
  } bp_update_t;

  // Steering from the register block
  typedef struct packed {
    logic predict_en;
    logic hist_clear;
  } bp_ctrl_t;

  // --------------------
  // AXI4-Lite
  // --------------------
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
  } axil_resp_t;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // Write channel sequencing
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } axil_wr_state_e;

  // Register map
  localparam axil_addr_t REG_CTRL    = 8'h00;
  localparam axil_addr_t REG_LOOKUPS = 8'h04;
  localparam axil_addr_t REG_TAKEN   = 8'h08;
  localparam axil_addr_t REG_GHIST   = 8'h0C;

endpackage

`default_nettype wire

// File: hw/bp_predictor.sv
// Predictor core, BTB lane pick plus gshare direction into s2
`timescale 1ns/1ps
`default_nettype none

module bp_predictor
  import bp_pkg::*;
#(
  parameter int unsigned BTB_IDX_W = 6,
  parameter int unsigned PHT_IDX_W = 8,
  parameter int unsigned GHIST_W   = 8
) (
  input  wire                 i_clk,
  input  wire                 i_arst_n,
  input  wire                 i_s0_valid,
  input  vaddr_t              i_s0_pc,
  input  bp_update_t          i_update,
  input  bp_ctrl_t            i_ctrl,
  output logic                o_s1_btb_hit,
  output vaddr_t              o_s1_btb_target,
  output logic                o_s2_predict_valid,
  output vaddr_t              o_s2_predict_target,
  output logic                o_s2_lookup,
  output logic                o_s2_taken_evt,
  output logic [GHIST_W-1:0]  o_ghist
);

  lane_mask_t   w_s1_hit_mask;
  vaddr_t [3:0] w_s1_targets;
  lane_mask_t   w_s1_offset_mask;
  lane_mask_t   w_s1_cand;
  lane_mask_t   w_s1_sel_oh;
  lane_idx_t    w_s1_lane;
  vaddr_t       w_s1_target;
  lane_idx_t    r_s1_offset;
  logic         r_s1_valid;
  logic         r_s2_valid;
  logic         r_s2_hit;
  vaddr_t       r_s2_target;
  logic         w_s2_taken;

  bp_btb #(
    .BTB_IDX_W (BTB_IDX_W)
  ) u_btb (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_s0_valid    (i_s0_valid),
    .i_s0_pc       (i_s0_pc),
    .i_update      (i_update),
    .o_s1_hit_mask (w_s1_hit_mask),
    .o_s1_targets  (w_s1_targets)
  );

  bp_gshare #(
    .PHT_IDX_W (PHT_IDX_W),
    .GHIST_W   (GHIST_W)
  ) u_gshare (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_s0_valid   (i_s0_valid),
    .i_s0_pc      (i_s0_pc),
    .i_s1_lane    (w_s1_lane),
    .i_update     (i_update),
    .i_hist_clear (i_ctrl.hist_clear),
    .o_s2_taken   (w_s2_taken),
    .o_ghist      (o_ghist)
  );

  // --------------------
  // s1 lane select
  // --------------------
  // Lanes before the fetch offset are not fetched
  assign w_s1_offset_mask = lane_mask_t'(4'hf << r_s1_offset);
  assign w_s1_cand        = w_s1_hit_mask & w_s1_offset_mask;
  // Isolate lowest set bit
  assign w_s1_sel_oh      = w_s1_cand & lane_mask_t'(~w_s1_cand + 4'd1);

  always_comb begin
    w_s1_target = '0;
    w_s1_lane   = '0;
    for (int l = 0; l < 4; l++) begin
      if (w_s1_sel_oh[l]) begin
        w_s1_target = w_s1_target | w_s1_targets[l];
        w_s1_lane   = w_s1_lane | lane_idx_t'(l);
      end
    end
  end

  assign o_s1_btb_hit    = |w_s1_cand;
  assign o_s1_btb_target = w_s1_target;

  // --------------------
  // Stage valids
  // --------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid;
      r_s2_valid <= r_s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_s0_valid) begin
      r_s1_offset <= i_s0_pc[3:2];
    end
    r_s2_hit    <= o_s1_btb_hit;
    r_s2_target <= w_s1_target;
  end

  // Taken only with a BTB target and a taken counter
  assign o_s2_predict_valid  = r_s2_valid && i_ctrl.predict_en && r_s2_hit && w_s2_taken;
  assign o_s2_predict_target = r_s2_target;
  assign o_s2_lookup         = r_s2_valid;
  assign o_s2_taken_evt      = o_s2_predict_valid;

  a_sel_onehot : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    r_s1_valid |-> $onehot0(w_s1_sel_oh)
  );

  // A prediction is always counted as a lookup
  a_pred_is_lookup : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_s2_predict_valid |-> o_s2_lookup
  );

endmodule

`default_nettype wire

// File: hw/bp_top.sv
// Branch predictor front end top, predictor core and AXI4-Lite registers
`timescale 1ns/1ps
`default_nettype none

module bp_top
  import bp_pkg::*;
#(
  parameter int unsigned BTB_IDX_W = 6,
  parameter int unsigned PHT_IDX_W = 8,
  parameter int unsigned GHIST_W   = 8
) (
  input  wire         i_clk,
  input  wire         i_arst_n,
  input  wire         i_s0_valid,
  input  vaddr_t      i_s0_pc,
  input  bp_update_t  i_update,
  input  axil_req_t   i_axil,
  output axil_resp_t  o_axil,
  output logic        o_s1_btb_hit,
  output vaddr_t      o_s1_btb_target,
  output logic        o_s2_predict_valid,
  output vaddr_t      o_s2_predict_target
);

  bp_ctrl_t           w_ctrl;
  logic               w_lookup_evt;
  logic               w_taken_evt;
  logic [GHIST_W-1:0] w_ghist;

  // History must fit inside the PHT index
  if (GHIST_W > PHT_IDX_W) begin : g_cfg_check
    $error("GHIST_W exceeds PHT_IDX_W");
  end

  // --------------------
  // Predictor
  // --------------------
  bp_predictor #(
    .BTB_IDX_W (BTB_IDX_W),
    .PHT_IDX_W (PHT_IDX_W),
    .GHIST_W   (GHIST_W)
  ) u_predictor (
    .i_clk               (i_clk),
    .i_arst_n            (i_arst_n),
    .i_s0_valid          (i_s0_valid),
    .i_s0_pc             (i_s0_pc),
    .i_update            (i_update),
    .i_ctrl              (w_ctrl),
    .o_s1_btb_hit        (o_s1_btb_hit),
    .o_s1_btb_target     (o_s1_btb_target),
    .o_s2_predict_valid  (o_s2_predict_valid),
    .o_s2_predict_target (o_s2_predict_target),
    .o_s2_lookup         (w_lookup_evt),
    .o_s2_taken_evt      (w_taken_evt),
    .o_ghist             (w_ghist)
  );

  // --------------------
  // Register block
  // --------------------
  bp_csr #(
    .GHIST_W (GHIST_W)
  ) u_csr (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_axil       (i_axil),
    .o_axil       (o_axil),
    .o_ctrl       (w_ctrl),
    .i_lookup_evt (w_lookup_evt),
    .i_taken_evt  (w_taken_evt),
    .i_ghist      (w_ghist)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the branch predictor testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_bp_top \
  -f all.f

./obj_dir/Vtb_bp_top | tee sim.log

if grep -q "^Regression passed$" sim.log; then
  exit 0
else
  echo "Simulation log has no pass line" >&2
  exit 1
fi

// File: sim/tb_bp_top.sv
// Branch predictor front end testbench with reference model and table-driven checks
`timescale 1ns/1ps
`default_nettype none

module tb_bp_top
  import bp_pkg::*;
();

  localparam int unsigned BTB_IDX_W = 6;
  localparam int unsigned PHT_IDX_W = 8;
  localparam int unsigned GHIST_W   = 8;
  localparam int unsigned BTB_ROWS  = 1 << BTB_IDX_W;
  localparam int unsigned PHT_ROWS  = 1 << PHT_IDX_W;
  localparam int unsigned MAX_ROWS  = 64;

  typedef enum logic [1:0] {
    OP_UPDATE,
    OP_LOOKUP,
    OP_CSR_WR,
    OP_CSR_RD
  } op_e;

  logic       clk;
  logic       arst_n;
  logic       s0_valid;
  vaddr_t     s0_pc;
  bp_update_t upd;
  axil_req_t  axil_req;
  axil_resp_t axil_resp;
  logic       s1_hit;
  vaddr_t     s1_target;
  logic       s2_pred;
  vaddr_t     s2_target;

  // Stimulus table with one operation per row
  string       t_test  [MAX_ROWS];
  op_e         t_op    [MAX_ROWS];
  logic [31:0] t_a     [MAX_ROWS];
  logic [31:0] t_b     [MAX_ROWS];
  logic        t_taken [MAX_ROWS];
  logic        t_cond  [MAX_ROWS];
  int          n_rows;

  // Reference model state
  logic               m_btb_vld [BTB_ROWS][4];
  logic [31:0]        m_btb_tag [BTB_ROWS][4];
  logic [31:0]        m_btb_tgt [BTB_ROWS][4];
  logic [1:0]         m_pht     [PHT_ROWS][4];
  logic [GHIST_W-1:0] m_ghist;
  logic               m_pred_en;
  logic [31:0]        m_lookups;
  logic [31:0]        m_taken;

  // Lookups in flight with p1 due at +1 cycle and p2 at +2
  logic        p1_v;
  logic        p1_hit;
  logic        p1_pred;
  logic [31:0] p1_tgt;
  string       p1_test;
  logic        p2_v;
  logic        p2_pred;
  logic [31:0] p2_tgt;
  string       p2_test;

  int          errors;
  int          checks;
  int unsigned cycle_count;
  int unsigned cycle_limit;

  bp_top #(
    .BTB_IDX_W (BTB_IDX_W),
    .PHT_IDX_W (PHT_IDX_W),
    .GHIST_W   (GHIST_W)
  ) dut (
    .i_clk               (clk),
    .i_arst_n            (arst_n),
    .i_s0_valid          (s0_valid),
    .i_s0_pc             (s0_pc),
    .i_update            (upd),
    .i_axil              (axil_req),
    .o_axil              (axil_resp),
    .o_s1_btb_hit        (s1_hit),
    .o_s1_btb_target     (s1_target),
    .o_s2_predict_valid  (s2_pred),
    .o_s2_predict_target (s2_target)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compare_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", test, what, exp, act);
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  task automatic model_reset();
    for (int r = 0; r < BTB_ROWS; r++) begin
      for (int l = 0; l < 4; l++) begin
        m_btb_vld[r][l] = 1'b0;
        m_btb_tag[r][l] = '0;
        m_btb_tgt[r][l] = '0;
      end
    end
    // Weakly not taken everywhere
    for (int r = 0; r < PHT_ROWS; r++) begin
      for (int l = 0; l < 4; l++) begin
        m_pht[r][l] = 2'd1;
      end
    end
    m_ghist   = '0;
    m_pred_en = 1'b1;
    m_lookups = '0;
    m_taken   = '0;
  endtask

  task automatic model_train(input vaddr_t pc, input vaddr_t tgt, input logic tk,
                             input logic cd);
    logic [BTB_IDX_W-1:0] idx;
    logic [PHT_IDX_W-1:0] pidx;
    logic [1:0]           lane;
    idx  = pc[4 +: BTB_IDX_W];
    // Index from the history before this branch shifts in
    pidx = pc[4 +: PHT_IDX_W] ^ PHT_IDX_W'(m_ghist);
    lane = pc[3:2];
    if (tk) begin
      m_btb_vld[idx][lane] = 1'b1;
      m_btb_tag[idx][lane] = pc >> (4 + BTB_IDX_W);
      m_btb_tgt[idx][lane] = tgt;
    end
    if (cd) begin
      if (tk && m_pht[pidx][lane] != 2'd3) begin
        m_pht[pidx][lane] = m_pht[pidx][lane] + 2'd1;
      end else if (!tk && m_pht[pidx][lane] != 2'd0) begin
        m_pht[pidx][lane] = m_pht[pidx][lane] - 2'd1;
      end
      m_ghist = {m_ghist[GHIST_W-2:0], tk};
    end
  endtask

  task automatic model_predict(input vaddr_t pc, output logic hit, output vaddr_t tgt,
                               output logic pred);
    logic [BTB_IDX_W-1:0] idx;
    logic [PHT_IDX_W-1:0] pidx;
    logic [1:0]           lane;
    idx  = pc[4 +: BTB_IDX_W];
    pidx = pc[4 +: PHT_IDX_W] ^ PHT_IDX_W'(m_ghist);
    hit  = 1'b0;
    tgt  = '0;
    lane = 2'd0;
    // Walk down from lane 3 so the lowest match is left standing
    for (int l = 3; l >= 0; l--) begin
      if (l >= int'(pc[3:2]) && m_btb_vld[idx][l] &&
          m_btb_tag[idx][l] == (pc >> (4 + BTB_IDX_W))) begin
        hit  = 1'b1;
        tgt  = m_btb_tgt[idx][l];
        lane = 2'(l);
      end
    end
    pred = hit && m_pred_en && (m_pht[pidx][lane] >= 2'd2);
  endtask

  task automatic model_reg_write(input axil_addr_t addr, input logic [31:0] data);
    case (addr)
      REG_CTRL: begin
        m_pred_en = data[0];
        if (data[1]) begin
          m_ghist = '0;
        end
      end
      REG_LOOKUPS: m_lookups = '0;
      REG_TAKEN:   m_taken = '0;
      default: ;
    endcase
  endtask

  function automatic logic [31:0] model_reg_read(input axil_addr_t addr);
    case (addr)
      REG_CTRL:    return {31'd0, m_pred_en};
      REG_LOOKUPS: return m_lookups;
      REG_TAKEN:   return m_taken;
      REG_GHIST:   return 32'(m_ghist);
      default:     return 32'd0;
    endcase
  endfunction

  // --------------------
  // Cycle stepping
  // --------------------
  // Advance to the next falling edge where pulses end and due lookups are checked
  task automatic tick();
    @(negedge clk);
    s0_valid  = 1'b0;
    upd.valid = 1'b0;
    if (p2_v) begin
      compare_value(p2_test, "s2 predict valid", 32'(p2_pred), 32'(s2_pred));
      if (p2_pred) begin
        compare_value(p2_test, "s2 predict target", p2_tgt, s2_target);
      end
    end
    if (p1_v) begin
      compare_value(p1_test, "s1 btb hit", 32'(p1_hit), 32'(s1_hit));
      if (p1_hit) begin
        compare_value(p1_test, "s1 btb target", p1_tgt, s1_target);
      end
    end
    p2_v    = p1_v;
    p2_pred = p1_pred;
    p2_tgt  = p1_tgt;
    p2_test = p1_test;
    p1_v    = 1'b0;
  endtask

  task automatic drain();
    while (p1_v || p2_v) begin
      tick();
    end
    // One more edge so s2 events reach the counters
    tick();
  endtask

  // --------------------
  // AXI4-Lite master
  // --------------------
  task automatic axil_write(input string test, input axil_addr_t addr,
                            input logic [31:0] data);
    drain();
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    while (!axil_resp.awready) begin
      tick();
    end
    tick();
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    while (!axil_resp.wready) begin
      tick();
    end
    tick();
    axil_req.wvalid = 1'b0;
    axil_req.bready = 1'b1;
    while (!axil_resp.bvalid) begin
      tick();
    end
    compare_value(test, "bresp", 32'(AXI_RESP_OKAY), 32'(axil_resp.bresp));
    tick();
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input string test, input axil_addr_t addr,
                           output logic [31:0] data);
    drain();
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    while (!axil_resp.arready) begin
      tick();
    end
    tick();
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    while (!axil_resp.rvalid) begin
      tick();
    end
    data = axil_resp.rdata;
    compare_value(test, "rresp", 32'(AXI_RESP_OKAY), 32'(axil_resp.rresp));
    tick();
    axil_req.rready = 1'b0;
  endtask

  // --------------------
  // Table
  // --------------------
  task automatic add_row(input string test, input op_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic tk, input logic cd);
    t_test[n_rows]  = test;
    t_op[n_rows]    = op;
    t_a[n_rows]     = a;
    t_b[n_rows]     = b;
    t_taken[n_rows] = tk;
    t_cond[n_rows]  = cd;
    n_rows++;
  endtask

  // Word-aligned random address
  function automatic vaddr_t rand_addr();
    return $urandom & 32'hffff_fffc;
  endfunction

  task automatic build_table();
    vaddr_t pc_a;
    vaddr_t tgt_a;
    vaddr_t pc_b;
    vaddr_t tgt_b;
    vaddr_t blk_c;
    vaddr_t tgt_c1;
    vaddr_t tgt_c3;
    vaddr_t pc_d;
    vaddr_t tgt_d;
    pc_a   = rand_addr();
    tgt_a  = rand_addr();
    pc_b   = rand_addr();
    tgt_b  = rand_addr();
    blk_c  = rand_addr() & 32'hffff_fff0;
    tgt_c1 = rand_addr();
    tgt_c3 = rand_addr();
    pc_d   = rand_addr();
    tgt_d  = rand_addr();
    n_rows = 0;
    // Empty predictor
    add_row("reset", OP_LOOKUP, rand_addr(), 32'd0, 1'b0, 1'b0);
    add_row("reset", OP_LOOKUP, rand_addr(), 32'd0, 1'b0, 1'b0);
    add_row("reset", OP_LOOKUP, rand_addr(), 32'd0, 1'b0, 1'b0);
    add_row("reset", OP_CSR_RD, 32'(REG_CTRL), 32'd0, 1'b0, 1'b0);
    // A trained taken twice at a cleared history and B filled then trained not taken
    add_row("train", OP_CSR_WR, 32'(REG_CTRL), 32'd3, 1'b0, 1'b0);
    add_row("train", OP_UPDATE, pc_a, tgt_a, 1'b1, 1'b1);
    add_row("train", OP_CSR_WR, 32'(REG_CTRL), 32'd3, 1'b0, 1'b0);
    add_row("train", OP_UPDATE, pc_a, tgt_a, 1'b1, 1'b1);
    add_row("train", OP_CSR_WR, 32'(REG_CTRL), 32'd3, 1'b0, 1'b0);
    add_row("train", OP_LOOKUP, pc_a, 32'd0, 1'b0, 1'b0);
    add_row("train", OP_UPDATE, pc_b, tgt_b, 1'b1, 1'b0);
    add_row("train", OP_UPDATE, pc_b, tgt_b, 1'b0, 1'b1);
    add_row("train", OP_LOOKUP, pc_b, 32'd0, 1'b0, 1'b0);
    // Branches in lanes 1 and 3 of one block
    add_row("lanes", OP_UPDATE, blk_c + 32'd4, tgt_c1, 1'b1, 1'b0);
    add_row("lanes", OP_UPDATE, blk_c + 32'd12, tgt_c3, 1'b1, 1'b0);
    add_row("lanes", OP_LOOKUP, blk_c, 32'd0, 1'b0, 1'b0);
    add_row("lanes", OP_LOOKUP, blk_c + 32'd4, 32'd0, 1'b0, 1'b0);
    add_row("lanes", OP_LOOKUP, blk_c + 32'd8, 32'd0, 1'b0, 1'b0);
    add_row("lanes", OP_LOOKUP, blk_c + 32'd12, 32'd0, 1'b0, 1'b0);
    // Same row with another tag
    add_row("lanes", OP_LOOKUP, blk_c ^ 32'h0000_0400, 32'd0, 1'b0, 1'b0);
    // Ten taken fill the history with ones and one not taken follows
    add_row("ghist", OP_CSR_WR, 32'(REG_CTRL), 32'd3, 1'b0, 1'b0);
    for (int k = 0; k < 10; k++) begin
      add_row("ghist", OP_UPDATE, pc_d, tgt_d, 1'b1, 1'b1);
    end
    add_row("ghist", OP_LOOKUP, pc_d, 32'd0, 1'b0, 1'b0);
    add_row("ghist", OP_CSR_RD, 32'(REG_GHIST), 32'd0, 1'b0, 1'b0);
    add_row("ghist", OP_UPDATE, pc_d, tgt_d, 1'b0, 1'b1);
    add_row("ghist", OP_LOOKUP, pc_d, 32'd0, 1'b0, 1'b0);
    add_row("ghist", OP_CSR_RD, 32'(REG_GHIST), 32'd0, 1'b0, 1'b0);
    // Predictions off with a history clear, so A would predict if enabled
    add_row("control", OP_CSR_WR, 32'(REG_CTRL), 32'd2, 1'b0, 1'b0);
    add_row("control", OP_CSR_RD, 32'(REG_GHIST), 32'd0, 1'b0, 1'b0);
    add_row("control", OP_LOOKUP, pc_a, 32'd0, 1'b0, 1'b0);
    add_row("control", OP_CSR_RD, 32'(REG_CTRL), 32'd0, 1'b0, 1'b0);
    // Back on without a clear
    add_row("control", OP_CSR_WR, 32'(REG_CTRL), 32'd1, 1'b0, 1'b0);
    add_row("control", OP_LOOKUP, pc_a, 32'd0, 1'b0, 1'b0);
    // Event counters and their clear on write
    add_row("counters", OP_CSR_RD, 32'(REG_LOOKUPS), 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_CSR_RD, 32'(REG_TAKEN), 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_CSR_WR, 32'(REG_LOOKUPS), 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_CSR_WR, 32'(REG_TAKEN), 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_CSR_RD, 32'(REG_LOOKUPS), 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_CSR_RD, 32'(REG_TAKEN), 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_LOOKUP, pc_a, 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_CSR_RD, 32'(REG_LOOKUPS), 32'd0, 1'b0, 1'b0);
    add_row("counters", OP_CSR_RD, 32'(REG_TAKEN), 32'd0, 1'b0, 1'b0);
  endtask

  task automatic apply_row(input int r);
    logic        hit;
    logic        pred;
    vaddr_t      tgt;
    logic [31:0] exp;
    logic [31:0] act;
    case (t_op[r])
      OP_UPDATE: begin
        upd.valid   = 1'b1;
        upd.pc      = t_a[r];
        upd.target  = t_b[r];
        upd.taken   = t_taken[r];
        upd.is_cond = t_cond[r];
        model_train(t_a[r], t_b[r], t_taken[r], t_cond[r]);
        tick();
      end
      OP_LOOKUP: begin
        s0_valid = 1'b1;
        s0_pc    = t_a[r];
        model_predict(t_a[r], hit, tgt, pred);
        m_lookups = m_lookups + 32'd1;
        if (pred) begin
          m_taken = m_taken + 32'd1;
        end
        p1_v    = 1'b1;
        p1_hit  = hit;
        p1_pred = pred;
        p1_tgt  = tgt;
        p1_test = t_test[r];
        tick();
      end
      OP_CSR_WR: begin
        axil_write(t_test[r], t_a[r][7:0], t_b[r]);
        model_reg_write(t_a[r][7:0], t_b[r]);
      end
      default: begin
        exp = model_reg_read(t_a[r][7:0]);
        axil_read(t_test[r], t_a[r][7:0], act);
        compare_value(t_test[r], $sformatf("read 0x%02h", t_a[r][7:0]), exp, act);
      end
    endcase
  endtask

  // --------------------
  // Run
  // --------------------
  initial begin
    int unsigned seed_ret;
    int          err_mark;
    int          chk_mark;
    int          tests;
    arst_n   = 1'b0;
    s0_valid = 1'b0;
    s0_pc    = '0;
    upd      = '0;
    axil_req = '0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    err_mark = 0;
    chk_mark = 0;
    p1_v     = 1'b0;
    p2_v     = 1'b0;
    seed_ret = $urandom(62);
    build_table();
    cycle_limit = n_rows * 10 + 200;
    model_reset();
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
      // Test ends where the name changes
      if (r == n_rows - 1 || t_test[r + 1] != t_test[r]) begin
        drain();
        $display("test %s: %0d checks, %0d errors", t_test[r], checks - chk_mark,
                 errors - err_mark);
        tests++;
        chk_mark = checks;
        err_mark = errors;
      end
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog on cycles after reset
  initial begin
    cycle_count = 0;
    wait (arst_n === 1'b1);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire
